// ==== Bender.yml ====
package:
  name: ip_arb_mux

sources:
  - verilog/ip_mux_pkg.sv
  - verilog/frame_arbiter.sv
  - verilog/hdr_capture.sv
  - verilog/payload_path.sv
  - verilog/ip_arb_mux.sv
  - target: test
    files:
      - verif/tb_ip_arb_mux.sv

// ==== ip_arb_mux.f ====
verilog/ip_mux_pkg.sv
verilog/frame_arbiter.sv
verilog/hdr_capture.sv
verilog/payload_path.sv
verilog/ip_arb_mux.sv
verif/tb_ip_arb_mux.sv

// ==== verif/tb_ip_arb_mux.sv ====
`timescale 1ns/1ps

module tb_ip_arb_mux;

  typedef ip_mux_pkg::ip_hdr_t     hdr_list_t[$];
  typedef ip_mux_pkg::ip_payload_t beat_list_t[$];

  localparam int timeout_cycles = 500;

  logic                                              clk;
  logic                                              rst;
  ip_mux_pkg::port_mask_t                            s_hdr_valid;
  ip_mux_pkg::port_mask_t                            s_hdr_ready;
  ip_mux_pkg::ip_hdr_t [ip_mux_pkg::s_count-1:0]     s_hdr;
  ip_mux_pkg::port_mask_t                            s_valid;
  ip_mux_pkg::port_mask_t                            s_ready;
  ip_mux_pkg::ip_payload_t [ip_mux_pkg::s_count-1:0] s_payload;
  logic                                              m_hdr_valid;
  logic                                              m_hdr_ready;
  ip_mux_pkg::ip_hdr_t                               m_hdr;
  logic                                              m_valid;
  logic                                              m_ready;
  ip_mux_pkg::ip_payload_t                           m_payload;

  hdr_list_t   hdr_q;
  beat_list_t  beat_q;
  int          hdr_pulses [ip_mux_pkg::s_count];
  logic        random_ready;
  logic        hold_hdr;
  int          errors;
  int          timeouts;
  event        timed_out;

  ip_arb_mux uut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_hdr(input string test, input ip_mux_pkg::ip_hdr_t expected,
                           input ip_mux_pkg::ip_hdr_t actual);
    if (actual !== expected) begin
      $display("** Error [%s] header: expected %h, actual %h", test, expected, actual);
      errors++;
    end
  endtask

  task automatic check_beat(input string test, input ip_mux_pkg::ip_payload_t expected,
                            input ip_mux_pkg::ip_payload_t actual);
    if (actual !== expected) begin
      $display("** Error [%s] beat: expected %h, actual %h", test, expected, actual);
      errors++;
    end
  endtask

  task automatic check_bit(input string test, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("** Error [%s] bit: expected %b, actual %b", test, expected, actual);
      errors++;
    end
  endtask

  task automatic finish_run();
    $display("summary: %0d check errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s", what);
    timeouts++;
    -> timed_out;
  endtask

  // ends the run as soon as any wait gives up
  initial begin
    @(timed_out);
    finish_run();
  end

  // output side sampled mid-cycle where every signal there is registered
  task automatic collect_outputs();
    forever begin
      @(negedge clk);
      m_ready = random_ready ? 1'($urandom_range(1, 0)) : 1'b1;
      m_hdr_ready = !hold_hdr;
      if (m_valid && m_ready) begin
        beat_q.push_back(m_payload);
      end
      if (m_hdr_valid && m_hdr_ready) begin
        hdr_q.push_back(m_hdr);
      end
      for (int p = 0; p < ip_mux_pkg::s_count; p++) begin
        if (s_hdr_ready[p]) begin
          hdr_pulses[p]++;
        end
      end
    end
  endtask

  function automatic ip_mux_pkg::ip_hdr_t random_hdr();
    logic [287:0] bits;
    for (int i = 0; i < 9; i++) begin
      bits[i*32 +: 32] = $urandom;
    end
    return bits[$bits(ip_mux_pkg::ip_hdr_t)-1:0];
  endfunction

  function automatic beat_list_t build_frame(input logic [7:0] first, input int count);
    beat_list_t              beats;
    ip_mux_pkg::ip_payload_t beat;
    for (int i = 0; i < count; i++) begin
      beat.data = first + 8'(i);
      beat.last = (i == count - 1);
      beat.user = 1'($urandom_range(1, 0));
      beats.push_back(beat);
    end
    return beats;
  endfunction

  // header first and payload only once the header has been taken
  task automatic send_frame(input int port, input ip_mux_pkg::ip_hdr_t hdr,
                            input beat_list_t beats);
    int waited;
    @(negedge clk);
    s_hdr[port] = hdr;
    s_hdr_valid[port] = 1'b1;
    waited = 0;
    while (!s_hdr_ready[port]) begin
      if (waited == timeout_cycles) begin
        report_timeout($sformatf("no header ready on port %0d", port));
      end
      @(negedge clk);
      waited++;
    end
    @(negedge clk);
    s_hdr_valid[port] = 1'b0;
    foreach (beats[i]) begin
      s_valid[port] = 1'b1;
      s_payload[port] = beats[i];
      waited = 0;
      while (!s_ready[port]) begin
        if (waited == timeout_cycles) begin
          report_timeout($sformatf("beat stuck on port %0d", port));
        end
        @(negedge clk);
        waited++;
      end
      @(negedge clk);
    end
    s_valid[port] = 1'b0;
  endtask

  task automatic expect_outputs(input string test, input hdr_list_t exp_hdrs,
                                input beat_list_t exp_beats);
    int waited;
    waited = 0;
    @(posedge clk);
    while (hdr_q.size() < exp_hdrs.size() || beat_q.size() < exp_beats.size()) begin
      if (waited == timeout_cycles) begin
        report_timeout($sformatf("%s output incomplete", test));
      end
      @(posedge clk);
      waited++;
    end
    // idle a little so duplicated beats would show up
    repeat (4) @(posedge clk);
    if (hdr_q.size() != exp_hdrs.size() || beat_q.size() != exp_beats.size()) begin
      $display("** Error [%s] counts: expected %0d/%0d, actual %0d/%0d", test,
               exp_hdrs.size(), exp_beats.size(), hdr_q.size(), beat_q.size());
      errors++;
    end
    foreach (exp_hdrs[i]) begin
      if (i < hdr_q.size()) begin
        check_hdr(test, exp_hdrs[i], hdr_q[i]);
      end
    end
    foreach (exp_beats[i]) begin
      if (i < beat_q.size()) begin
        check_beat(test, exp_beats[i], beat_q[i]);
      end
    end
    hdr_q.delete();
    beat_q.delete();
  endtask

  task automatic reset_state();
    check_bit("reset", 1'b0, m_hdr_valid);
    check_bit("reset", 1'b0, m_valid);
    for (int p = 0; p < ip_mux_pkg::s_count; p++) begin
      check_bit("reset", 1'b0, s_hdr_ready[p]);
      check_bit("reset", 1'b0, s_ready[p]);
    end
  endtask

  task automatic single_frame();
    ip_mux_pkg::ip_hdr_t hdr;
    beat_list_t          beats;
    hdr = random_hdr();
    beats = build_frame(8'h20, 5);
    hdr_pulses = '{default: 0};
    send_frame(2, hdr, beats);
    expect_outputs("single_frame", {hdr}, beats);
    if (hdr_pulses[2] != 1) begin
      $display("** Error [single_frame] port 2 header ready pulses: expected 1, actual %0d",
               hdr_pulses[2]);
      errors++;
    end
  endtask

  // port 1 outranks port 3 and whole frames leave in grant order
  task automatic priority_order();
    ip_mux_pkg::ip_hdr_t hdr_1;
    ip_mux_pkg::ip_hdr_t hdr_3;
    beat_list_t          beats_1;
    beat_list_t          beats_3;
    hdr_1 = random_hdr();
    hdr_3 = random_hdr();
    beats_1 = build_frame(8'h10, 4);
    beats_3 = build_frame(8'h30, 6);
    fork
      send_frame(3, hdr_3, beats_3);
      send_frame(1, hdr_1, beats_1);
    join
    expect_outputs("priority", {hdr_1, hdr_3}, {beats_1, beats_3});
  endtask

  task automatic payload_backpressure();
    ip_mux_pkg::ip_hdr_t hdr;
    beat_list_t          beats;
    hdr = random_hdr();
    beats = build_frame(8'h40, 40);
    random_ready = 1'b1;
    send_frame(0, hdr, beats);
    expect_outputs("backpressure", {hdr}, beats);
    random_ready = 1'b0;
  endtask

  task automatic header_hold();
    ip_mux_pkg::ip_hdr_t hdr_a;
    ip_mux_pkg::ip_hdr_t hdr_b;
    beat_list_t          beats_a;
    beat_list_t          beats_b;
    int                  waited;
    hdr_a = random_hdr();
    hdr_b = random_hdr();
    beats_a = build_frame(8'h80, 5);
    beats_b = build_frame(8'h90, 3);
    hold_hdr = 1'b1;
    fork
      send_frame(0, hdr_a, beats_a);
      send_frame(1, hdr_b, beats_b);
      begin
        waited = 0;
        while (beat_q.size() < beats_a.size()) begin
          if (waited == timeout_cycles) begin
            report_timeout("first frame never drained");
          end
          @(posedge clk);
          waited++;
        end
        // stalled first header stays put while the second port waits
        repeat (6) begin
          @(negedge clk);
          check_bit("hdr_hold", 1'b1, m_hdr_valid);
          check_hdr("hdr_hold", hdr_a, m_hdr);
          check_bit("hdr_hold", 1'b0, s_hdr_ready[1]);
        end
        @(posedge clk);
        hold_hdr = 1'b0;
      end
    join
    expect_outputs("hdr_hold", {hdr_a, hdr_b}, {beats_a, beats_b});
  endtask

  initial begin
    void'($urandom(32'h56d8dca5));
    rst = 1'b1;
    s_hdr_valid = '0;
    s_hdr = '0;
    s_valid = '0;
    s_payload = '0;
    m_hdr_ready = 1'b0;
    m_ready = 1'b0;
    random_ready = 1'b0;
    hold_hdr = 1'b0;
    errors = 0;
    timeouts = 0;
    hdr_pulses = '{default: 0};
    fork
      collect_outputs();
    join_none
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    reset_state();
    single_frame();
    priority_order();
    payload_backpressure();
    header_hold();
    finish_run();
  end

endmodule

// ==== verilog/frame_arbiter.sv ====
`timescale 1ns/1ps

module frame_arbiter (
  input  logic                   clk,
  input  logic                   rst,
  input  ip_mux_pkg::port_mask_t request,
  input  logic                   frame_done,
  output ip_mux_pkg::port_mask_t grant,
  output logic                   grant_valid,
  output ip_mux_pkg::sel_t       grant_index
);

  ip_mux_pkg::port_mask_t pick;
  ip_mux_pkg::sel_t       pick_index;

  // lowest index wins, so scan downwards and let the last hit stand
  always_comb begin
    pick = '0;
    pick_index = '0;
    for (int i = ip_mux_pkg::s_count - 1; i >= 0; i--) begin
      if (request[i]) begin
        pick = '0;
        pick[i] = 1'b1;
        pick_index = ip_mux_pkg::sel_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      grant <= '0;
      grant_valid <= 1'b0;
      grant_index <= '0;
    end else if (grant_valid) begin
      // held until the last beat of the frame goes through
      if (frame_done) begin
        grant <= '0;
        grant_valid <= 1'b0;
      end
    end else if (|request) begin
      grant <= pick;
      grant_valid <= 1'b1;
      grant_index <= pick_index;
    end
  end

  // grant is one-hot or idle, and grant_valid tracks it
  assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant) && (grant_valid == (grant != '0)));

endmodule

// ==== verilog/hdr_capture.sv ====
`timescale 1ns/1ps

module hdr_capture (
  input  logic                                          clk,
  input  logic                                          rst,
  input  ip_mux_pkg::ip_hdr_t [ip_mux_pkg::s_count-1:0] s_hdr,
  input  ip_mux_pkg::port_mask_t                        grant,
  input  logic                                          grant_valid,
  input  ip_mux_pkg::sel_t                              grant_index,
  input  logic                                          frame_done,
  input  logic                                          m_hdr_ready,
  output ip_mux_pkg::port_mask_t                        s_hdr_ready,
  output logic                                          m_hdr_valid,
  output ip_mux_pkg::ip_hdr_t                           m_hdr
);

  logic frame_open;
  logic hdr_free;
  logic start_frame;

  // output register empty or being taken this cycle
  assign hdr_free = !m_hdr_valid || m_hdr_ready;

  // a frame finishing this cycle has to release its grant first
  assign start_frame = grant_valid && !frame_open && !frame_done && hdr_free;

  always_ff @(posedge clk) begin
    if (rst) begin
      frame_open <= 1'b0;
      s_hdr_ready <= '0;
      m_hdr_valid <= 1'b0;
    end else begin
      // ready is a single cycle pulse
      s_hdr_ready <= '0;
      if (start_frame) begin
        frame_open <= 1'b1;
        s_hdr_ready <= grant;
        m_hdr_valid <= 1'b1;
      end else begin
        if (frame_done) begin
          frame_open <= 1'b0;
        end
        if (m_hdr_ready) begin
          m_hdr_valid <= 1'b0;
        end
      end
    end
  end

  // header register loaded from the granted port
  always_ff @(posedge clk) begin
    if (start_frame) begin
      m_hdr <= s_hdr[grant_index];
    end
  end

  // header ready only ever goes to the port holding the grant
  assert property (@(posedge clk) disable iff (rst)
    (s_hdr_ready & ~grant) == '0);

endmodule

// ==== verilog/ip_arb_mux.sv ====
`timescale 1ns/1ps

module ip_arb_mux (
  input  logic                                              clk,
  input  logic                                              rst,

  // source ports
  input  ip_mux_pkg::port_mask_t                            s_hdr_valid,
  output ip_mux_pkg::port_mask_t                            s_hdr_ready,
  input  ip_mux_pkg::ip_hdr_t [ip_mux_pkg::s_count-1:0]     s_hdr,
  input  ip_mux_pkg::port_mask_t                            s_valid,
  output ip_mux_pkg::port_mask_t                            s_ready,
  input  ip_mux_pkg::ip_payload_t [ip_mux_pkg::s_count-1:0] s_payload,

  // output port
  output logic                                              m_hdr_valid,
  input  logic                                              m_hdr_ready,
  output ip_mux_pkg::ip_hdr_t                               m_hdr,
  output logic                                              m_valid,
  input  logic                                              m_ready,
  output ip_mux_pkg::ip_payload_t                           m_payload
);

  ip_mux_pkg::port_mask_t grant;
  logic                   grant_valid;
  ip_mux_pkg::sel_t       grant_index;
  logic                   frame_done;

  // a presented header is the request
  frame_arbiter arb (
    .clk         (clk),
    .rst         (rst),
    .request     (s_hdr_valid),
    .frame_done  (frame_done),
    .grant       (grant),
    .grant_valid (grant_valid),
    .grant_index (grant_index)
  );

  hdr_capture hdr (
    .clk         (clk),
    .rst         (rst),
    .s_hdr       (s_hdr),
    .grant       (grant),
    .grant_valid (grant_valid),
    .grant_index (grant_index),
    .frame_done  (frame_done),
    .m_hdr_ready (m_hdr_ready),
    .s_hdr_ready (s_hdr_ready),
    .m_hdr_valid (m_hdr_valid),
    .m_hdr       (m_hdr)
  );

  payload_path payload (
    .clk         (clk),
    .rst         (rst),
    .s_valid     (s_valid),
    .s_payload   (s_payload),
    .grant       (grant),
    .grant_valid (grant_valid),
    .grant_index (grant_index),
    .m_ready     (m_ready),
    .s_ready     (s_ready),
    .m_valid     (m_valid),
    .m_payload   (m_payload),
    .frame_done  (frame_done)
  );

endmodule

// ==== verilog/ip_mux_pkg.sv ====
package ip_mux_pkg;

  // port count and field widths
  localparam int s_count    = 4;
  localparam int sel_width  = $clog2(s_count);
  localparam int data_width = 8;
  localparam int user_width = 1;

  typedef logic [47:0] mac_t;
  typedef logic [31:0] ipv4_t;

  typedef logic [sel_width-1:0] sel_t;
  typedef logic [s_count-1:0]   port_mask_t;

  // ethernet + ipv4 header, 273 bits
  typedef struct packed {
    mac_t        dest_mac;
    mac_t        src_mac;
    logic [15:0] eth_type;
    logic [3:0]  version;
    logic [3:0]  ihl;
    logic [5:0]  dscp;
    logic [1:0]  ecn;
    logic [15:0] length;
    logic [15:0] identification;
    logic [2:0]  flags;
    logic [12:0] fragment_offset;
    logic [7:0]  ttl;
    logic [7:0]  protocol;
    logic [15:0] header_checksum;
    ipv4_t       source_ip;
    ipv4_t       dest_ip;
    // rocev2 frame marker
    logic        is_roce;
  } ip_hdr_t;

  // one payload beat
  typedef struct packed {
    logic [data_width-1:0] data;
    logic                  last;
    logic [user_width-1:0] user;
  } ip_payload_t;

endpackage

// ==== verilog/payload_path.sv ====
`timescale 1ns/1ps

module payload_path (
  input  logic                                              clk,
  input  logic                                              rst,
  input  ip_mux_pkg::port_mask_t                            s_valid,
  input  ip_mux_pkg::ip_payload_t [ip_mux_pkg::s_count-1:0] s_payload,
  input  ip_mux_pkg::port_mask_t                            grant,
  input  logic                                              grant_valid,
  input  ip_mux_pkg::sel_t                                  grant_index,
  input  logic                                              m_ready,
  output ip_mux_pkg::port_mask_t                            s_ready,
  output logic                                              m_valid,
  output ip_mux_pkg::ip_payload_t                           m_payload,
  output logic                                              frame_done
);

  ip_mux_pkg::ip_payload_t in_payload;
  logic                    in_valid;
  logic                    in_ready;
  logic                    ready_reg;
  logic                    ready_early;

  ip_mux_pkg::ip_payload_t temp_payload;
  logic                    temp_valid;

  logic                    m_valid_next;
  logic                    temp_valid_next;
  logic                    store_in_to_out;
  logic                    store_in_to_temp;
  logic                    store_temp_to_out;

  // granted stream
  assign in_payload = s_payload[grant_index];
  assign in_ready = ready_reg && grant_valid;
  assign in_valid = s_valid[grant_index] && in_ready;

  // ready only towards the granted port
  assign s_ready = grant & {ip_mux_pkg::s_count{ready_reg}};

  assign frame_done = in_valid && in_payload.last;

  // accept next cycle if output drains or both entries are empty
  assign ready_early = (m_ready || (!temp_valid && !m_valid)) && grant_valid;

  always_comb begin
    m_valid_next = m_valid;
    temp_valid_next = temp_valid;
    store_in_to_out = 1'b0;
    store_in_to_temp = 1'b0;
    store_temp_to_out = 1'b0;

    if (in_ready) begin
      if (m_ready || !m_valid) begin
        m_valid_next = in_valid;
        store_in_to_out = 1'b1;
      end else begin
        // output stalled so the beat is parked
        temp_valid_next = in_valid;
        store_in_to_temp = 1'b1;
      end
    end else if (m_ready) begin
      m_valid_next = temp_valid;
      temp_valid_next = 1'b0;
      store_temp_to_out = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid <= 1'b0;
      temp_valid <= 1'b0;
      ready_reg <= 1'b0;
    end else begin
      m_valid <= m_valid_next;
      temp_valid <= temp_valid_next;
      ready_reg <= ready_early;
    end
  end

  // beat storage
  always_ff @(posedge clk) begin
    if (store_in_to_out) begin
      m_payload <= in_payload;
    end else if (store_temp_to_out) begin
      m_payload <= temp_payload;
    end
    if (store_in_to_temp) begin
      temp_payload <= in_payload;
    end
  end

  // skid entry only fills behind a full output register
  assert property (@(posedge clk) disable iff (rst)
    temp_valid |-> m_valid);

endmodule
